//--- sources.f
+incdir+logic
logic/music_pkg.sv
logic/score_rom.sv
logic/note_sequencer.sv
logic/tone_generator.sv
logic/segment_display.sv
logic/music_top.sv
verif/music_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the tune player testbench with Verilator and runs it
set -u

cd "$(dirname "$0")" || exit 1

build_dir=obj_dir
build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -j 0 \
  --top-module music_tb -f sources.f \
  --Mdir "$build_dir" -o music_sim > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  cat "$build_log"
  echo "build failed"
  exit 1
fi

"./$build_dir/music_sim" > "$sim_log" 2>&1
sim_status=$?
cat "$sim_log"

if grep -q "Result: FAILED" "$sim_log"; then
  echo "simulation reported a failure"
  exit 1
fi
if [ "$sim_status" -ne 0 ]; then
  echo "simulation exited with status $sim_status"
  exit 1
fi
echo "simulation finished cleanly"
exit 0

//--- verif/music_tb.sv
`timescale 1ns/1ns
`default_nettype none

module music_tb;
  import music_pkg::*;

  `include "song_tables.svh"

  localparam int BEAT_MS         = 3;
  localparam int CLK_PERIOD      = 40;
  localparam int DRIVE_DELAY     = 2;
  localparam int NUM_RUNS        = 4;
  localparam int SLACK           = 8;       // cycles of grace before a wait gives up
  localparam int WATCHDOG_CYCLES = 200000;

  logic       clk;
  logic       rst;
  tick_t      ticks_per_milli;
  logic       sound;
  logic [7:0] led;

  logic [31:0] lfsr_state;
  int          model_part;  // part of the note about to sound
  int          model_idx;
  int          tpm;

  music_top #(
    .BEAT_MS(BEAT_MS)
  ) dut0 (
    .clk            (clk),
    .rst            (rst),
    .ticks_per_milli(ticks_per_milli),
    .sound          (sound),
    .led            (led)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    report_timeout("simulation ran past its cycle limit");
  end

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] state);
    logic feedback;
    feedback = state[31] ^ state[21] ^ state[1] ^ state[0];
    return {state[30:0], feedback};
  endfunction

  function automatic int draw_bits(input int count);
    int value;
    value = 0;
    for (int i = 0; i < count; i++) begin
      lfsr_state = lfsr_next(lfsr_state);
      value = (value << 1) | int'(lfsr_state[0]);
    end
    return value;
  endfunction

  function automatic section_e section_of(input int part);
    case (part)
      1, 2:    return SEC_INTRO;
      3, 5:    return SEC_VERSE;
      default: return SEC_CHORUS;
    endcase
  endfunction

  function automatic int notes_in_part(input int part);
    case (section_of(part))
      SEC_INTRO: return INTRO_LEN;
      SEC_VERSE: return VERSE_LEN;
      default:   return CHORUS_LEN;
    endcase
  endfunction

  function automatic int pitch_of(input int part, input int idx);
    logic [3:0] row;
    row = idx[3:0];
    case (section_of(part))
      SEC_INTRO: return int'(INTRO_PITCH[row]);
      SEC_VERSE: return int'(VERSE_PITCH[row]);
      default:   return int'(CHORUS_PITCH[row]);
    endcase
  endfunction

  function automatic int length_ms_of(input int part, input int idx);
    logic [3:0] row;
    row = idx[3:0];
    case (section_of(part))
      SEC_INTRO: return int'(INTRO_BEATS[row]) * BEAT_MS;
      SEC_VERSE: return int'(VERSE_BEATS[row]) * BEAT_MS * VERSE_STRETCH;
      default:   return int'(CHORUS_BEATS[row]) * BEAT_MS;
    endcase
  endfunction

  function automatic logic [6:0] digit_segments(input int digit);
    case (digit)
      1:       return 7'b0000110;
      2:       return 7'b1011011;
      3:       return 7'b1001111;
      4:       return 7'b1100110;
      5:       return 7'b1101101;
      6:       return 7'b1111100;  // six drawn without its top bar
      default: return 7'b0000000;
    endcase
  endfunction

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic report_timeout(input string what);
    $display("ERROR: timed out, %s", what);
    stop_with_failure();
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("FAILED %s: expected %0d, actual %0d", name, expected, actual);
      stop_with_failure();
    end
  endtask

  task automatic next_sample();
    @(negedge clk);  // outputs settle well before the falling edge
  endtask

  // tpm only changes while rst is high
  task automatic apply_reset(input int new_tpm);
    if (rst !== 1'b1) begin
      @(posedge clk);
      #(DRIVE_DELAY);
      rst = 1'b1;
    end
    ticks_per_milli = tick_t'(new_tpm);
    repeat (3) @(posedge clk);
    #(DRIVE_DELAY);
    rst = 1'b0;
    next_sample();
    check_value("dot after reset", 0, 32'(led[7]));
    check_value("sound after reset", 0, 32'(sound));
    check_value("digit after reset", 32'(digit_segments(1)), 32'(led[6:0]));
    model_part = 1;
    model_idx  = 0;
  endtask

  task automatic wait_dot_rise(input int limit);
    int waited;
    waited = 0;
    while (led[7] !== 1'b1) begin
      if (waited >= limit) begin
        report_timeout("dot did not rise after reset");
      end
      waited++;
      next_sample();
    end
  endtask

  // starts on the first dot-high sample, ends on the next note's first one
  task automatic play_note();
    int   len_ms;
    int   gap_ms;
    int   pitch;
    int   high_cnt;
    int   low_cnt;
    int   toggles;
    int   expected_toggles;
    int   toggle_report;
    logic prev_sound;

    len_ms           = length_ms_of(model_part, model_idx);
    gap_ms           = len_ms / 3;
    pitch            = pitch_of(model_part, model_idx);
    expected_toggles = (2 * pitch * len_ms) / 1000;
    high_cnt         = 0;
    toggles          = 0;
    check_value("sound at note start", 0, 32'(sound));
    prev_sound = sound;

    while (led[7] === 1'b1) begin
      check_value("digit while sounding", 32'(digit_segments(model_part)), 32'(led[6:0]));
      if (pitch == 0) begin
        check_value("sound during rest", 0, 32'(sound));
      end
      if (high_cnt > len_ms * tpm + SLACK) begin
        report_timeout("dot stayed high past the note length");
      end
      high_cnt++;
      next_sample();
      if (sound !== prev_sound) begin
        toggles++;
      end
      prev_sound = sound;
    end
    check_value("dot high time", len_ms * tpm, high_cnt);

    // one toggle of slack either way
    if ((toggles + 1 >= expected_toggles) && (toggles <= expected_toggles + 1)) begin
      toggle_report = expected_toggles;
    end else begin
      toggle_report = toggles;
    end
    check_value("tone toggle count", expected_toggles, toggle_report);

    low_cnt = 1;  // first low sample may still carry the last toggle
    next_sample();
    while (led[7] !== 1'b1) begin
      check_value("sound during gap", 0, 32'(sound));
      if (low_cnt > gap_ms * tpm + 1 + SLACK) begin
        report_timeout("dot stayed low past the gap");
      end
      low_cnt++;
      next_sample();
    end
    check_value("dot low time", gap_ms * tpm + 1, low_cnt);

    model_idx++;
    if (model_idx == notes_in_part(model_part)) begin
      model_idx  = 0;
      model_part = (model_part == int'(NUM_PARTS)) ? 1 : model_part + 1;
    end
  endtask

  initial begin
    int notes_to_play;
    int extra_cycles;
    int loop_notes;

    rst             = 1'b1;
    ticks_per_milli = tick_t'(4);
    lfsr_state      = 32'h5fa3af09;
    model_part      = 1;
    model_idx       = 0;
    tpm             = 4;
    loop_notes      = 2 * (INTRO_LEN + VERSE_LEN + CHORUS_LEN);

    for (int run = 0; run < NUM_RUNS; run++) begin
      tpm = 4 + draw_bits(2);
      $display("run %0d with %0d ticks per ms", run, tpm);
      apply_reset(tpm);  // lands mid-song after the first run
      wait_dot_rise(SLACK);
      if (run == 0) begin
        notes_to_play = loop_notes + 1;  // full loop plus the wrap note
      end else begin
        notes_to_play = 1 + draw_bits(5);
      end
      for (int n = 0; n < notes_to_play; n++) begin
        play_note();
      end
      extra_cycles = draw_bits(8);  // stop somewhere inside the next note
      repeat (extra_cycles) next_sample();
    end

    tpm = 4 + draw_bits(2);
    $display("final reset with %0d ticks per ms", tpm);
    apply_reset(tpm);
    wait_dot_rise(SLACK);
    play_note();

    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- logic/music_top.sv
`timescale 1ns/1ns
`default_nettype none

module music_top #(
  parameter int BEAT_MS = 100
) (
  input  logic             clk,
  input  logic             rst,
  input  music_pkg::tick_t ticks_per_milli,
  output logic             sound,
  output logic [7:0]       led
);
  import music_pkg::*;

  part_t     part;
  part_t     shown_part;
  note_idx_t note_idx;
  freq_t     pitch;
  freq_t     freq;
  ms_t       note_ms;
  logic      last_note;
  logic      sounding;

  score_rom #(
    .BEAT_MS(BEAT_MS)
  ) rom0 (
    .part     (part),
    .note_idx (note_idx),
    .pitch    (pitch),
    .note_ms  (note_ms),
    .last_note(last_note)
  );

  note_sequencer seq0 (
    .clk            (clk),
    .rst            (rst),
    .ticks_per_milli(ticks_per_milli),
    .pitch          (pitch),
    .note_ms        (note_ms),
    .last_note      (last_note),
    .part           (part),
    .shown_part     (shown_part),
    .note_idx       (note_idx),
    .freq           (freq),
    .sounding       (sounding)
  );

  tone_generator tone0 (
    .clk            (clk),
    .rst            (rst),
    .ticks_per_milli(ticks_per_milli),
    .freq           (freq),
    .sound          (sound)
  );

  segment_display disp0 (
    .shown_part(shown_part),
    .sounding  (sounding),
    .led       (led)
  );

endmodule

`default_nettype wire

//--- logic/segment_display.sv
`timescale 1ns/1ns
`default_nettype none

module segment_display (
  input  music_pkg::part_t shown_part,
  input  logic             sounding,
  output logic [7:0]       led
);

  logic [6:0] segments;  // bit 0 is the top bar, bit 6 the middle

  always_comb begin
    case (shown_part)
      3'd0:    segments = 7'b0111111;
      3'd1:    segments = 7'b0000110;
      3'd2:    segments = 7'b1011011;
      3'd3:    segments = 7'b1001111;
      3'd4:    segments = 7'b1100110;
      3'd5:    segments = 7'b1101101;
      3'd6:    segments = 7'b1111100;  // six without the top bar
      default: segments = 7'b0000000;
    endcase
  end

  assign led = {sounding, segments};  // dot on while a note sounds

endmodule

`default_nettype wire

//--- logic/tone_generator.sv
`timescale 1ns/1ns
`default_nettype none

module tone_generator (
  input  logic             clk,
  input  logic             rst,
  input  music_pkg::tick_t ticks_per_milli,
  input  music_pkg::freq_t freq,
  output logic             sound
);

  logic [31:0] half_sec;  // cycles in half a second
  logic [31:0] acc;

  assign half_sec = 32'(ticks_per_milli) * 32'd500;

  // two toggles per period, so freq toggles every half second of cycles
  always_ff @(posedge clk) begin
    if (rst) begin
      acc   <= '0;
      sound <= 1'b0;
    end else if (freq == '0) begin
      acc   <= '0;  // rest or gap
      sound <= 1'b0;
    end else if (acc >= half_sec) begin
      acc   <= acc + 32'(freq) - half_sec;
      sound <= ~sound;
    end else begin
      acc <= acc + 32'(freq);
    end
  end

  // holds as long as each note starts from a cleared accumulator
  a_acc_bound: assert property (@(posedge clk) disable iff (rst)
    (freq != '0) |-> (acc < half_sec + 32'(freq)))
    else $error("accumulator %0d overran threshold %0d", acc, half_sec);

endmodule

`default_nettype wire

//--- logic/note_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

module note_sequencer (
  input  logic                 clk,
  input  logic                 rst,
  input  music_pkg::tick_t     ticks_per_milli,
  input  music_pkg::freq_t     pitch,
  input  music_pkg::ms_t       note_ms,
  input  logic                 last_note,
  output music_pkg::part_t     part,
  output music_pkg::part_t     shown_part,
  output music_pkg::note_idx_t note_idx,
  output music_pkg::freq_t     freq,
  output logic                 sounding
);
  import music_pkg::*;

  typedef enum logic [1:0] {
    PH_LOAD,
    PH_SOUND,
    PH_GAP
  } phase_e;

  phase_e phase;
  tick_t  tick_cnt;    // cycles into the current ms
  ms_t    ms_cnt;      // ms into the current phase
  ms_t    note_len;
  ms_t    gap_len;
  ms_t    phase_len;
  logic   milli_done;
  logic   phase_done;

  assign milli_done = (tick_cnt == ticks_per_milli - tick_t'(1));
  assign phase_len  = (phase == PH_GAP) ? gap_len : note_len;
  assign phase_done = milli_done && (ms_cnt == phase_len - ms_t'(1));

  // note lengths only change in the load cycle
  always_ff @(posedge clk) begin
    if (phase == PH_LOAD) begin
      note_len <= note_ms;
      gap_len  <= note_ms / ms_t'(3);  // silence is a third of the note
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      phase      <= PH_LOAD;
      tick_cnt   <= '0;
      ms_cnt     <= '0;
      part       <= part_t'(1);
      shown_part <= part_t'(1);
      note_idx   <= '0;
      freq       <= '0;
      sounding   <= 1'b0;
    end else begin
      case (phase)
        PH_LOAD: begin
          freq       <= pitch;  // zero for a rest
          sounding   <= 1'b1;
          shown_part <= part;   // display follows the note, not the pointer
          tick_cnt   <= '0;
          ms_cnt     <= '0;
          phase      <= PH_SOUND;
          if (last_note) begin
            note_idx <= '0;
            part     <= (part == NUM_PARTS) ? part_t'(1) : part + part_t'(1);
          end else begin
            note_idx <= note_idx + note_idx_t'(1);
          end
        end
        default: begin  // sound and gap count the same way
          if (milli_done) begin
            tick_cnt <= '0;
            ms_cnt   <= ms_cnt + ms_t'(1);
          end else begin
            tick_cnt <= tick_cnt + tick_t'(1);
          end
          if (phase_done) begin
            ms_cnt <= '0;
            if (phase == PH_SOUND) begin
              freq     <= '0;
              sounding <= 1'b0;
              // very short notes have no gap at all
              phase    <= (gap_len != '0) ? PH_GAP : PH_LOAD;
            end else begin
              phase <= PH_LOAD;
            end
          end
        end
      endcase
    end
  end

  a_part_range: assert property (@(posedge clk) disable iff (rst)
    (part >= part_t'(1)) && (part <= NUM_PARTS))
    else $error("part %0d out of range", part);

  // the tone generator relies on a zero pitch to go quiet
  a_quiet_when_off: assert property (@(posedge clk) disable iff (rst)
    !sounding |-> (freq == '0))
    else $error("freq %0d while not sounding", freq);

endmodule

`default_nettype wire

//--- logic/score_rom.sv
`timescale 1ns/1ns
`default_nettype none

module score_rom #(
  parameter int BEAT_MS = 100
) (
  input  music_pkg::part_t     part,
  input  music_pkg::note_idx_t note_idx,
  output music_pkg::freq_t     pitch,
  output music_pkg::ms_t       note_ms,
  output logic                 last_note
);
  import music_pkg::*;

  `include "song_tables.svh"

  section_e   section;
  logic [3:0] row;         // no section holds more than 16 notes
  beats_t     beats;
  ms_t        beat_scale;  // ms per beat for this section

  assign section = part_section(part);
  assign row     = note_idx[3:0];

  always_comb begin
    case (section)
      SEC_INTRO: begin
        pitch      = INTRO_PITCH[row];
        beats      = INTRO_BEATS[row];
        beat_scale = ms_t'(BEAT_MS);
      end
      SEC_VERSE: begin
        pitch      = VERSE_PITCH[row];
        beats      = VERSE_BEATS[row];
        beat_scale = ms_t'(BEAT_MS * VERSE_STRETCH);  // slower verse
      end
      default: begin  // chorus
        pitch      = CHORUS_PITCH[row];
        beats      = CHORUS_BEATS[row];
        beat_scale = ms_t'(BEAT_MS);
      end
    endcase
  end

  assign note_ms   = ms_t'(beats) * beat_scale;
  assign last_note = (note_idx == section_len(section) - note_idx_t'(1));

  // the sequencer must wrap to note 0 before running off a table
  always_comb begin
    if (!$isunknown(note_idx)) begin
      a_idx_in_section: assert (note_idx < section_len(section))
        else $error("note index %0d past end of section %0d", note_idx, part);
    end
  end

endmodule

`default_nettype wire

//--- logic/music_pkg.sv
`default_nettype none

package music_pkg;

  typedef logic [9:0]  freq_t;      // Hz, zero is a rest
  typedef logic [3:0]  beats_t;
  typedef logic [15:0] ms_t;
  typedef logic [15:0] tick_t;      // clock cycles within one ms
  typedef logic [2:0]  part_t;      // 1 to 6
  typedef logic [5:0]  note_idx_t;

  typedef enum logic [1:0] {
    SEC_INTRO,
    SEC_VERSE,
    SEC_CHORUS
  } section_e;

  localparam part_t NUM_PARTS = 3'd6;

  localparam int INTRO_LEN  = 13;
  localparam int VERSE_LEN  = 16;
  localparam int CHORUS_LEN = 16;

  localparam int VERSE_STRETCH = 2;  // verse notes are played at half tempo

  // song order is intro, intro, verse, chorus, verse, chorus
  function automatic section_e part_section(part_t part);
    case (part)
      3'd1, 3'd2: return SEC_INTRO;
      3'd3, 3'd5: return SEC_VERSE;
      default:    return SEC_CHORUS;
    endcase
  endfunction

  function automatic note_idx_t section_len(section_e section);
    case (section)
      SEC_INTRO: return note_idx_t'(INTRO_LEN);
      SEC_VERSE: return note_idx_t'(VERSE_LEN);
      default:   return note_idx_t'(CHORUS_LEN);
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/song_tables.svh
// pitch in Hz per note, zero marks a rest
localparam music_pkg::freq_t INTRO_PITCH [music_pkg::INTRO_LEN] = '{
  10'd554,  // c5s
  10'd622,  // e5f
  10'd622,  // e5f
  10'd698,  // f5
  10'd831,  // a5f
  10'd740,  // f5s
  10'd698,  // f5
  10'd622,  // e5f
  10'd554,  // c5s
  10'd622,  // e5f
  10'd0,    // rest
  10'd415,  // a4f
  10'd415   // a4f
};

localparam music_pkg::beats_t INTRO_BEATS [music_pkg::INTRO_LEN] = '{
  4'd6, 4'd10, 4'd6, 4'd6, 4'd1, 4'd1, 4'd1,
  4'd1, 4'd6, 4'd10, 4'd4, 4'd2, 4'd10
};

localparam music_pkg::freq_t VERSE_PITCH [music_pkg::VERSE_LEN] = '{
  10'd0,    // rest
  10'd277,  // c4s
  10'd277,  // c4s
  10'd277,  // c4s
  10'd277,  // c4s
  10'd311,  // e4f
  10'd0,    // rest
  10'd261,  // c4
  10'd233,  // b3f
  10'd208,  // a3f
  10'd0,    // rest
  10'd233,  // b3f
  10'd233,  // b3f
  10'd261,  // c4
  10'd277,  // c4s
  10'd208   // a3f
};

localparam music_pkg::beats_t VERSE_BEATS [music_pkg::VERSE_LEN] = '{
  4'd6, 4'd1, 4'd1, 4'd1, 4'd1, 4'd2, 4'd1, 4'd1,
  4'd1, 4'd5, 4'd1, 4'd1, 4'd1, 4'd1, 4'd3, 4'd1
};

localparam music_pkg::freq_t CHORUS_PITCH [music_pkg::CHORUS_LEN] = '{
  10'd466,  // b4f
  10'd466,  // b4f
  10'd415,  // a4f
  10'd415,  // a4f
  10'd698,  // f5
  10'd698,  // f5
  10'd622,  // e5f
  10'd466,  // b4f
  10'd466,  // b4f
  10'd415,  // a4f
  10'd415,  // a4f
  10'd622,  // e5f
  10'd622,  // e5f
  10'd554,  // c5s
  10'd523,  // c5
  10'd466   // b4f
};

localparam music_pkg::beats_t CHORUS_BEATS [music_pkg::CHORUS_LEN] = '{
  4'd1, 4'd1, 4'd1, 4'd1, 4'd3, 4'd3, 4'd6, 4'd1,
  4'd1, 4'd1, 4'd1, 4'd3, 4'd3, 4'd3, 4'd1, 4'd2
};
